// ==== include/pcie_mmio_consts.svh ====
`ifndef PCIE_MMIO_CONSTS_SVH
`define PCIE_MMIO_CONSTS_SVH

// Start-up timing in cfg_clk cycles
// PERST stretch counter width, pulse of 2^n-1 cycles
`define PERST_PULSE_BITS 5
// Start counter bit that releases the TLP logic
`define START_DLY_BIT 6
// Start counter bit that marks PERST done
`define PERST_DONE_BIT 7
// Blink rate of the heartbeat LED
`define HEARTBEAT_BIT 4

// Buffer sizes
`define MMIO_WORDS 64
`define CPL_FIFO_DEPTH 4

// bardec bit of the MMIO test BAR
`define BAR_MMIO 3

// TLP fmt field codes
`define FMT_MRD32 3'b000
`define FMT_MRD64 3'b001
`define FMT_MWR32 3'b010
`define FMT_MWR64 3'b011
`define FMT_CPLD 3'b010

// TLP type field codes
`define TYPE_MEM 5'b00000
`define TYPE_CPL 5'b01010

`endif

// ==== src/pcie_mmio_pkg.sv ====
`include "pcie_mmio_consts.svh"

package pcie_mmio_pkg;

    // One TLP data word
    typedef logic [31:0] dw_t;
    // One core beat, DW n at bits 32n+31:32n
    typedef logic [255:0] tlp_data_t;
    // One bit per DW of a beat
    typedef logic [7:0] dw_valid_t;
    // BAR hit mask from the core
    typedef logic [5:0] bardec_t;
    // Bus number and device number
    typedef logic [12:0] busdev_t;
    typedef logic [15:0] req_id_t;
    typedef logic [7:0] tag_t;
    // Word index into the MMIO RAM
    typedef logic [$clog2(`MMIO_WORDS)-1:0] mmio_idx_t;
    typedef logic [3:0] led_t;

    // RX beat as the core delivers it
    typedef struct packed {
        logic      sop;
        logic      eop;
        dw_valid_t valid;
        tlp_data_t data;
        bardec_t   bardec;
    } rx_beat_t;

    // TX beat toward the core
    typedef struct packed {
        logic      sop;
        logic      eop;
        dw_valid_t valid;
        tlp_data_t data;
    } tx_beat_t;

    // Decoded single-DW memory request
    typedef struct packed {
        logic       is_write;
        req_id_t    req_id;
        tag_t       tag;
        mmio_idx_t  idx;
        logic [6:0] lower_addr;
        dw_t        wdata;
    } mem_req_t;

    // Start-up sequencer states
    typedef enum logic [1:0] {
        RST_HOLD,
        RST_WAIT_START,
        RST_RUN
    } rst_state_t;

endpackage

// ==== src/pcie_rst_seq.sv ====
`timescale 1ns/1ps
`include "pcie_mmio_consts.svh"

module pcie_rst_seq (
    input  logic cfg_clk,
    input  logic rstn,
    input  logic pcie_rstn_i,
    output logic sys_rstn_o,
    output logic perst_done_o,
    output logic tlp_run_o
);

    logic                         pcie_rstn_q;
    logic [`PERST_PULSE_BITS-1:0] perst_cnt;
    logic [`PERST_DONE_BIT:0]     st_cnt;
    logic [`PERST_DONE_BIT:0]     st_cnt_nxt;
    pcie_mmio_pkg::rst_state_t    state;

    // PERST falling edge loads the stretch counter
    // PERST going high ends the pulse early
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            pcie_rstn_q <= 1'b0;
            perst_cnt   <= '0;
        end else begin
            pcie_rstn_q <= pcie_rstn_i;
            if (pcie_rstn_q && !pcie_rstn_i) begin
                perst_cnt <= '1;
            end else if (pcie_rstn_i) begin
                perst_cnt <= '0;
            end else if (perst_cnt != '0) begin
                perst_cnt <= perst_cnt - 1'b1;
            end
        end
    end

    // Combined reset for everything behind the sequencer
    assign sys_rstn_o = rstn & (perst_cnt == '0);

    assign st_cnt_nxt = st_cnt + 1'b1;

    // Start delay, restarts after every combined reset
    always_ff @(posedge cfg_clk or negedge sys_rstn_o) begin
        if (!sys_rstn_o) begin
            state  <= pcie_mmio_pkg::RST_HOLD;
            st_cnt <= '0;
        end else begin
            case (state)
                // Wait here while PERST is still asserted
                pcie_mmio_pkg::RST_HOLD: begin
                    if (pcie_rstn_i) begin
                        state  <= pcie_mmio_pkg::RST_WAIT_START;
                        st_cnt <= st_cnt_nxt;
                    end
                end
                pcie_mmio_pkg::RST_WAIT_START: begin
                    st_cnt <= st_cnt_nxt;
                    // Switch on the edge that sets the start bit
                    if (st_cnt_nxt[`START_DLY_BIT]) begin
                        state <= pcie_mmio_pkg::RST_RUN;
                    end
                end
                default: begin
                    // Keep counting up to the PERST done mark, then hold
                    if (!st_cnt[`PERST_DONE_BIT]) begin
                        st_cnt <= st_cnt_nxt;
                    end
                end
            endcase
        end
    end

    assign tlp_run_o    = (state == pcie_mmio_pkg::RST_RUN);
    assign perst_done_o = st_cnt[`PERST_DONE_BIT];

    // TLP logic only stops through the combined reset
    assert property (@(posedge cfg_clk) disable iff (!rstn)
        sys_rstn_o |-> !$fell(tlp_run_o))
        else $error("tlp_run_o fell while sys_rstn_o was high");

endmodule

// ==== src/status_led.sv ====
`timescale 1ns/1ps
`include "pcie_mmio_consts.svh"

module status_led (
    input  logic                cfg_clk,
    input  logic                rstn,
    input  logic                perst_done_i,
    input  logic                tlp_run_i,
    input  logic                pcie_linkup_i,
    output pcie_mmio_pkg::led_t led_o
);

    logic [`HEARTBEAT_BIT:0] hb_cnt;
    logic                    linkup_q;

    // Free-running blink counter, link-up sampled on cfg_clk
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            hb_cnt   <= '0;
            linkup_q <= 1'b0;
        end else begin
            hb_cnt   <= hb_cnt + 1'b1;
            linkup_q <= pcie_linkup_i;
        end
    end

    // LEDs light on a low level
    // Heartbeat
    assign led_o[0] = ~hb_cnt[`HEARTBEAT_BIT];
    // On while PERST not done
    assign led_o[1] = ~perst_done_i;
    // On while TLP logic held
    assign led_o[2] = ~tlp_run_i;
    // On while link down
    assign led_o[3] = ~linkup_q;

endmodule

// ==== src/tlp_mem_dec.sv ====
`timescale 1ns/1ps
`include "pcie_mmio_consts.svh"

module tlp_mem_dec (
    input  logic                    cfg_clk,
    input  logic                    rstn,
    input  logic                    tlp_run_i,
    input  pcie_mmio_pkg::rx_beat_t tl_rx_i,
    output pcie_mmio_pkg::mem_req_t mem_req_o,
    output logic                    req_valid_o
);

    localparam int IDX_W = $bits(pcie_mmio_pkg::mmio_idx_t);

    pcie_mmio_pkg::dw_t hdr_dw0;
    pcie_mmio_pkg::dw_t hdr_dw1;
    pcie_mmio_pkg::dw_t addr_dw;
    pcie_mmio_pkg::dw_t data_dw;
    logic [2:0]         fmt;
    logic [4:0]         typ;
    logic [9:0]         len;
    logic               is_4dw;
    logic               fmt_ok;
    logic               hit;

    // Header fields at spec positions
    assign hdr_dw0 = tl_rx_i.data[31:0];
    assign hdr_dw1 = tl_rx_i.data[63:32];
    assign fmt     = hdr_dw0[31:29];
    assign typ     = hdr_dw0[28:24];
    assign len     = hdr_dw0[9:0];

    // fmt bit 0 set means 4DW header, low address then in DW3
    assign is_4dw  = fmt[0];
    assign addr_dw = is_4dw ? tl_rx_i.data[127:96] : tl_rx_i.data[95:64];
    // Payload DW follows the header
    assign data_dw = is_4dw ? tl_rx_i.data[159:128] : tl_rx_i.data[127:96];

    // Memory read or write, either header size
    assign fmt_ok = (fmt == `FMT_MRD32) || (fmt == `FMT_MRD64) ||
                    (fmt == `FMT_MWR32) || (fmt == `FMT_MWR64);

    // BAR3 single-DW memory request on a start beat
    assign hit = tlp_run_i && tl_rx_i.sop && tl_rx_i.bardec[`BAR_MMIO] &&
                 fmt_ok && (typ == `TYPE_MEM) && (len == 10'd1);

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= hit;
        end
    end

    // Request fields, captured only on a hit
    always_ff @(posedge cfg_clk) begin
        if (hit) begin
            // fmt bit 1 marks a request with data
            mem_req_o.is_write   <= fmt[1];
            mem_req_o.req_id     <= hdr_dw1[31:16];
            mem_req_o.tag        <= hdr_dw1[15:8];
            mem_req_o.idx        <= addr_dw[IDX_W+1:2];
            mem_req_o.lower_addr <= {addr_dw[6:2], 2'b00};
            mem_req_o.wdata      <= data_dw;
        end
    end

    // Core hands over these requests as one complete beat
    assert property (@(posedge cfg_clk) disable iff (!rstn)
        hit |-> tl_rx_i.eop)
        else $error("accepted MMIO request without eop on its start beat");

endmodule

// ==== src/mmio_target.sv ====
`timescale 1ns/1ps
`include "pcie_mmio_consts.svh"

module mmio_target (
    input  logic                    cfg_clk,
    input  logic                    rstn,
    input  logic                    tlp_run_i,
    input  pcie_mmio_pkg::busdev_t  tl_cfg_busdev_i,
    input  pcie_mmio_pkg::mem_req_t mem_req_i,
    input  logic                    req_valid_i,
    output pcie_mmio_pkg::tx_beat_t cpl_beat_o,
    output logic                    cpl_push_o
);

    // MMIO test RAM
    pcie_mmio_pkg::dw_t     mem [`MMIO_WORDS];

    pcie_mmio_pkg::req_id_t cpl_id;
    pcie_mmio_pkg::dw_t     cpl_dw0;
    pcie_mmio_pkg::dw_t     cpl_dw1;
    pcie_mmio_pkg::dw_t     cpl_dw2;
    logic                   do_wr;
    logic                   do_rd;

    assign do_wr = req_valid_i && tlp_run_i && mem_req_i.is_write;
    assign do_rd = req_valid_i && tlp_run_i && !mem_req_i.is_write;

    // Bus and device from config space, function 0
    assign cpl_id = {tl_cfg_busdev_i, 3'b000};

    // CplD, TC and attributes 0, one DW
    assign cpl_dw0 = {`FMT_CPLD, `TYPE_CPL, 14'd0, 10'd1};
    // Status successful, BCM 0, byte count 4
    assign cpl_dw1 = {cpl_id, 3'b000, 1'b0, 12'd4};
    // Requester id, tag, reserved bit, lower address
    assign cpl_dw2 = {mem_req_i.req_id, mem_req_i.tag, 1'b0, mem_req_i.lower_addr};

    // Full DW write, byte enables ignored
    always_ff @(posedge cfg_clk) begin
        if (do_wr) begin
            mem[mem_req_i.idx] <= mem_req_i.wdata;
        end
    end

    // RAM read and completion build in the same cycle
    always_ff @(posedge cfg_clk) begin
        if (do_rd) begin
            cpl_beat_o.sop   <= 1'b1;
            cpl_beat_o.eop   <= 1'b1;
            // 3DW header plus one data DW
            cpl_beat_o.valid <= 8'h0F;
            cpl_beat_o.data  <= {128'd0, mem[mem_req_i.idx], cpl_dw2, cpl_dw1, cpl_dw0};
        end
    end

    // One push per read, writes are posted
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            cpl_push_o <= 1'b0;
        end else begin
            cpl_push_o <= do_rd;
        end
    end

endmodule

// ==== src/cpl_tx_queue.sv ====
`timescale 1ns/1ps
`include "pcie_mmio_consts.svh"

module cpl_tx_queue (
    input  logic                    cfg_clk,
    input  logic                    rstn,
    input  logic                    tlp_run_i,
    input  logic                    pcie_linkup_i,
    input  logic                    tl_tx_wait_i,
    input  pcie_mmio_pkg::tx_beat_t cpl_beat_i,
    input  logic                    cpl_push_i,
    input  logic                    req_valid_i,
    output pcie_mmio_pkg::tx_beat_t tl_tx_o,
    output logic                    tl_rx_wait_o
);

    localparam int PTR_W = $clog2(`CPL_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`CPL_FIFO_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = `CPL_FIFO_DEPTH;
    localparam logic [CNT_W:0]   WAIT_LVL = `CPL_FIFO_DEPTH - 1;

    pcie_mmio_pkg::tx_beat_t   fifo_mem [`CPL_FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          fifo_cnt;
    logic [CNT_W:0]            occ;
    logic                      pop;
    logic                      tx_sop_q;
    logic                      tx_eop_q;
    pcie_mmio_pkg::dw_valid_t  tx_valid_q;
    pcie_mmio_pkg::tlp_data_t  tx_data_q;

    // Head leaves only when the core can take a beat
    assign pop = (fifo_cnt != '0) && !tl_tx_wait_i && pcie_linkup_i && tlp_run_i;

    always_ff @(posedge cfg_clk) begin
        if (cpl_push_i) begin
            fifo_mem[wr_ptr] <= cpl_beat_i;
        end
    end

    // Pointers wrap, depth is a power of two
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (cpl_push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cpl_push_i, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    // Output strobes, cleared whenever nothing is popped
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            tx_sop_q   <= 1'b0;
            tx_eop_q   <= 1'b0;
            tx_valid_q <= '0;
        end else if (pop) begin
            tx_sop_q   <= fifo_mem[rd_ptr].sop;
            tx_eop_q   <= fifo_mem[rd_ptr].eop;
            tx_valid_q <= fifo_mem[rd_ptr].valid;
        end else begin
            tx_sop_q   <= 1'b0;
            tx_eop_q   <= 1'b0;
            tx_valid_q <= '0;
        end
    end

    always_ff @(posedge cfg_clk) begin
        if (pop) begin
            tx_data_q <= fifo_mem[rd_ptr].data;
        end
    end

    assign tl_tx_o = {tx_sop_q, tx_eop_q, tx_valid_q, tx_data_q};

    // Stored entries plus reads still in the decoder or the target
    assign occ = {1'b0, fifo_cnt} + {{CNT_W{1'b0}}, req_valid_i} +
                 {{CNT_W{1'b0}}, cpl_push_i};
    // One slot kept for a beat already on the RX bus
    assign tl_rx_wait_o = (occ >= WAIT_LVL);

    // RX wait must stop the core before the FIFO overflows
    assert property (@(posedge cfg_clk) disable iff (!rstn)
        cpl_push_i |-> (fifo_cnt != FULL_CNT))
        else $error("completion pushed into a full FIFO");

endmodule

// ==== src/pcie_mmio_top.sv ====
`timescale 1ns/1ps

module pcie_mmio_top (
    input  logic                    cfg_clk,
    input  logic                    rstn,
    input  logic                    pcie_rstn_i,
    input  logic                    pcie_linkup_i,
    input  pcie_mmio_pkg::busdev_t  tl_cfg_busdev_i,
    input  pcie_mmio_pkg::rx_beat_t tl_rx_i,
    output logic                    tl_rx_wait_o,
    output pcie_mmio_pkg::tx_beat_t tl_tx_o,
    input  logic                    tl_tx_wait_i,
    output pcie_mmio_pkg::led_t     led_o
);

    // Reset and start-up
    logic                    sys_rstn;
    logic                    perst_done;
    logic                    tlp_run;
    // Decoded BAR3 request
    pcie_mmio_pkg::mem_req_t mem_req;
    logic                    req_valid;
    // Completion toward the TX queue
    pcie_mmio_pkg::tx_beat_t cpl_beat;
    logic                    cpl_push;

    pcie_rst_seq u_rst_seq (
        .cfg_clk      (cfg_clk),
        .rstn         (rstn),
        .pcie_rstn_i  (pcie_rstn_i),
        .sys_rstn_o   (sys_rstn),
        .perst_done_o (perst_done),
        .tlp_run_o    (tlp_run)
    );

    status_led u_status_led (
        .cfg_clk       (cfg_clk),
        .rstn          (sys_rstn),
        .perst_done_i  (perst_done),
        .tlp_run_i     (tlp_run),
        .pcie_linkup_i (pcie_linkup_i),
        .led_o         (led_o)
    );

    // BAR3 steering and header decode
    tlp_mem_dec u_mem_dec (
        .cfg_clk     (cfg_clk),
        .rstn        (sys_rstn),
        .tlp_run_i   (tlp_run),
        .tl_rx_i     (tl_rx_i),
        .mem_req_o   (mem_req),
        .req_valid_o (req_valid)
    );

    mmio_target u_mmio_target (
        .cfg_clk         (cfg_clk),
        .rstn            (sys_rstn),
        .tlp_run_i       (tlp_run),
        .tl_cfg_busdev_i (tl_cfg_busdev_i),
        .mem_req_i       (mem_req),
        .req_valid_i     (req_valid),
        .cpl_beat_o      (cpl_beat),
        .cpl_push_o      (cpl_push)
    );

    cpl_tx_queue u_cpl_tx (
        .cfg_clk       (cfg_clk),
        .rstn          (sys_rstn),
        .tlp_run_i     (tlp_run),
        .pcie_linkup_i (pcie_linkup_i),
        .tl_tx_wait_i  (tl_tx_wait_i),
        .cpl_beat_i    (cpl_beat),
        .cpl_push_i    (cpl_push),
        .req_valid_i   (req_valid),
        .tl_tx_o       (tl_tx_o),
        .tl_rx_wait_o  (tl_rx_wait_o)
    );

endmodule

// ==== test/tb_pcie_mmio.sv ====
`timescale 1ns/1ps
`include "pcie_mmio_consts.svh"

module tb_pcie_mmio;

    localparam int N_OPS = 13;
    localparam int K_WR = 0;
    localparam int K_RD = 1;
    localparam int K_IGN = 2;
    localparam int WD_CYCLES = N_OPS * 40 + 2000;
    localparam pcie_mmio_pkg::req_id_t REQ_ID = 16'h01A8;
    localparam pcie_mmio_pkg::busdev_t BUSDEV = 13'h0A5;

    // One table row per operation
    typedef struct packed {
        logic [1:0]             kind;
        pcie_mmio_pkg::bardec_t bardec;
        logic [2:0]             fmt;
        logic [4:0]             typ;
        logic [9:0]             len;
        pcie_mmio_pkg::dw_t     addr;
        pcie_mmio_pkg::dw_t     data;
        pcie_mmio_pkg::tag_t    tag;
        pcie_mmio_pkg::dw_t     exp;
    } op_t;

    logic                    cfg_clk;
    logic                    rstn;
    logic                    pcie_rstn_i;
    logic                    pcie_linkup_i;
    pcie_mmio_pkg::rx_beat_t tl_rx_i;
    logic                    tl_rx_wait_o;
    pcie_mmio_pkg::tx_beat_t tl_tx_o;
    logic                    tl_tx_wait_i;
    pcie_mmio_pkg::led_t     led_o;

    op_t                     ops [N_OPS];
    pcie_mmio_pkg::dw_t      model [`MMIO_WORDS];
    pcie_mmio_pkg::tx_beat_t cpl_q [$];
    int                      n_ops;
    int                      mismatches;
    int                      failures;
    integer                  seed;

    pcie_mmio_top u_dut (
        .cfg_clk         (cfg_clk),
        .rstn            (rstn),
        .pcie_rstn_i     (pcie_rstn_i),
        .pcie_linkup_i   (pcie_linkup_i),
        .tl_cfg_busdev_i (BUSDEV),
        .tl_rx_i         (tl_rx_i),
        .tl_rx_wait_o    (tl_rx_wait_o),
        .tl_tx_o         (tl_tx_o),
        .tl_tx_wait_i    (tl_tx_wait_i),
        .led_o           (led_o)
    );

    initial begin
        cfg_clk = 1'b0;
        forever #10 cfg_clk = ~cfg_clk;
    end

    // Completion beats sampled on the falling edge
    always @(negedge cfg_clk) begin
        if (tl_tx_o.sop) begin
            cpl_q.push_back(tl_tx_o);
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge cfg_clk);
        $display("Watchdog expired after %0d cycles, run did not finish", WD_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_dw(input string name, input pcie_mmio_pkg::dw_t got,
                            input pcie_mmio_pkg::dw_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_tag(input string name, input pcie_mmio_pkg::tag_t got,
                             input pcie_mmio_pkg::tag_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_id(input string name, input pcie_mmio_pkg::req_id_t got,
                            input pcie_mmio_pkg::req_id_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_led(input string name, input pcie_mmio_pkg::led_t got,
                             input pcie_mmio_pkg::led_t exp);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    // Append a table row and update the RAM model
    task automatic add_op(input int kind, input pcie_mmio_pkg::bardec_t bardec,
                          input logic [2:0] fmt, input logic [4:0] typ,
                          input logic [9:0] len, input pcie_mmio_pkg::dw_t addr);
        op_t op;
        op.kind   = kind[1:0];
        op.bardec = bardec;
        op.fmt    = fmt;
        op.typ    = typ;
        op.len    = len;
        op.addr   = addr;
        op.data   = $random(seed);
        op.tag    = $random(seed);
        op.exp    = model[addr[7:2]];
        if (kind == K_WR) begin
            model[addr[7:2]] = op.data;
        end
        ops[n_ops] = op;
        n_ops++;
    endtask

    // Request header at spec positions
    // 4DW header when fmt bit 0 is set
    function automatic pcie_mmio_pkg::rx_beat_t make_beat(input op_t op);
        pcie_mmio_pkg::rx_beat_t b;
        b        = '0;
        b.sop    = 1'b1;
        b.eop    = 1'b1;
        b.bardec = op.bardec;
        b.data[31:0]  = {op.fmt, op.typ, 14'd0, op.len};
        b.data[63:32] = {REQ_ID, op.tag, 8'h0F};
        if (op.fmt[0]) begin
            b.data[127:96]  = op.addr;
            b.data[159:128] = op.data;
            b.valid = op.fmt[1] ? 8'h1F : 8'h0F;
        end else begin
            b.data[95:64]  = op.addr;
            b.data[127:96] = op.data;
            b.valid = op.fmt[1] ? 8'h0F : 8'h07;
        end
        return b;
    endfunction

    // Holds off while the RX wait level is high
    task automatic send_beat(input op_t op);
        while (tl_rx_wait_o) @(negedge cfg_clk);
        tl_rx_i = make_beat(op);
        @(negedge cfg_clk);
        tl_rx_i = '0;
    endtask

    task automatic wait_cpl(output pcie_mmio_pkg::tx_beat_t beat, output bit ok,
                            input int max_cycles);
        ok = 1'b0;
        for (int i = 0; i < max_cycles && !ok; i++) begin
            if (cpl_q.size() != 0) begin
                beat = cpl_q.pop_front();
                ok   = 1'b1;
            end else begin
                @(negedge cfg_clk);
            end
        end
    endtask

    task automatic verify_cpl(input pcie_mmio_pkg::tx_beat_t b, input op_t op);
        // Single beat completion
        check_dw("cpl eop", {31'd0, b.eop}, 32'd1);
        check_dw("cpl dw0", b.data[31:0], {`FMT_CPLD, `TYPE_CPL, 14'd0, 10'd1});
        check_dw("cpl valid", {24'd0, b.valid}, 32'h0F);
        check_id("completer id", b.data[63:48], {BUSDEV, 3'b000});
        // Status 0 and BCM 0 sit above the byte count
        check_dw("status and byte count", {16'd0, b.data[47:32]}, 32'd4);
        check_id("requester id", b.data[95:80], REQ_ID);
        check_tag("cpl tag", b.data[79:72], op.tag);
        check_dw("lower addr", {25'd0, b.data[70:64]}, {25'd0, op.addr[6:2], 2'b00});
        check_dw("read data", b.data[127:96], op.exp);
    endtask

    // Single read checked against the RAM model
    task automatic read_back(input logic [2:0] fmt, input pcie_mmio_pkg::dw_t addr);
        op_t                     op;
        pcie_mmio_pkg::tx_beat_t b;
        bit                      ok;
        op = '{K_RD, 6'b001000, fmt, `TYPE_MEM, 10'd1, addr, 32'd0, 8'd0, 32'd0};
        op.tag = $random(seed);
        op.exp = model[addr[7:2]];
        send_beat(op);
        wait_cpl(b, ok, 60);
        if (!ok) begin
            $display("No completion for read of address %h", addr);
            failures++;
        end else begin
            verify_cpl(b, op);
        end
    endtask

    initial begin
        op_t                     op;
        op_t                     bp_ops [$];
        pcie_mmio_pkg::tx_beat_t b;
        pcie_mmio_pkg::led_t     hb;
        bit                      ok;
        bit                      seen;
        seed          = 40;
        mismatches    = 0;
        failures      = 0;
        n_ops         = 0;
        rstn          = 1'b0;
        pcie_rstn_i   = 1'b1;
        pcie_linkup_i = 1'b0;
        tl_tx_wait_i  = 1'b0;
        tl_rx_i       = '0;
        for (int i = 0; i < `MMIO_WORDS; i++) model[i] = 32'd0;

        // Writes, reads, then three ignored variants
        add_op(K_WR, 6'b001000, `FMT_MWR32, `TYPE_MEM, 10'd1, 32'h10);
        add_op(K_WR, 6'b001000, `FMT_MWR64, `TYPE_MEM, 10'd1, 32'h24);
        add_op(K_RD, 6'b001000, `FMT_MRD32, `TYPE_MEM, 10'd1, 32'h10);
        add_op(K_RD, 6'b001000, `FMT_MRD64, `TYPE_MEM, 10'd1, 32'h24);
        add_op(K_WR, 6'b001000, `FMT_MWR32, `TYPE_MEM, 10'd1, 32'h40);
        add_op(K_IGN, 6'b000001, `FMT_MWR32, `TYPE_MEM, 10'd1, 32'h10);
        add_op(K_IGN, 6'b001000, `FMT_MWR32, `TYPE_MEM, 10'd2, 32'h24);
        add_op(K_IGN, 6'b001000, `FMT_MWR32, 5'b00100, 10'd1, 32'h40);
        add_op(K_RD, 6'b001000, `FMT_MRD32, `TYPE_MEM, 10'd1, 32'h10);
        add_op(K_RD, 6'b001000, `FMT_MRD64, `TYPE_MEM, 10'd1, 32'h24);
        add_op(K_RD, 6'b001000, `FMT_MRD32, `TYPE_MEM, 10'd1, 32'h40);
        add_op(K_WR, 6'b001000, `FMT_MWR64, `TYPE_MEM, 10'd1, 32'hFC);
        add_op(K_RD, 6'b001000, `FMT_MRD64, `TYPE_MEM, 10'd1, 32'hFC);

        repeat (3) @(negedge cfg_clk);
        rstn = 1'b1;
        @(negedge cfg_clk);
        check_led("led_o[2]", led_o & 4'b0100, 4'b0100);
        check_led("led_o[3]", led_o & 4'b1000, 4'b1000);
        // Link LED goes dark within 2 cycles of link-up
        pcie_linkup_i = 1'b1;
        repeat (2) @(negedge cfg_clk);
        check_led("led_o[3]", led_o & 4'b1000, 4'b0000);
        repeat (56) @(negedge cfg_clk);
        check_led("led_o[2]", led_o & 4'b0100, 4'b0100);
        repeat (10) @(negedge cfg_clk);
        check_led("led_o[2]", led_o & 4'b0100, 4'b0000);
        // PERST done mark sits at counter bit 7
        repeat (70) @(negedge cfg_clk);
        check_led("led_o[1]", led_o & 4'b0010, 4'b0000);
        hb   = led_o & 4'b0001;
        seen = 1'b0;
        for (int i = 0; i < (1 << (`HEARTBEAT_BIT + 1)) && !seen; i++) begin
            @(negedge cfg_clk);
            seen = ((led_o & 4'b0001) != hb);
        end
        if (!seen) begin
            $display("Heartbeat LED did not toggle");
            failures++;
        end

        for (int i = 0; i < n_ops; i++) begin
            op = ops[i];
            send_beat(op);
            if (op.kind == K_RD) begin
                wait_cpl(b, ok, 60);
                if (!ok) begin
                    $display("No completion for table entry %0d", i);
                    failures++;
                end else begin
                    verify_cpl(b, op);
                end
            end else begin
                repeat (20) @(negedge cfg_clk);
                if (cpl_q.size() != 0) begin
                    $display("Unexpected completion after table entry %0d", i);
                    failures++;
                    cpl_q.delete();
                end
            end
        end

        // Hold TX wait high and issue reads until the RX wait rises
        tl_tx_wait_i = 1'b1;
        for (int i = 0; i < 8 && !tl_rx_wait_o; i++) begin
            op = '{K_RD, 6'b001000, `FMT_MRD32, `TYPE_MEM, 10'd1, 32'd0, 32'd0, 8'd0, 32'd0};
            op.addr = (i % 2) ? 32'h24 : 32'hFC;
            op.tag  = $random(seed);
            op.exp  = model[op.addr[7:2]];
            bp_ops.push_back(op);
            send_beat(op);
        end
        if (!tl_rx_wait_o) begin
            $display("RX wait never rose under TX back-pressure");
            failures++;
        end
        repeat (10) @(negedge cfg_clk);
        if (cpl_q.size() != 0) begin
            $display("Completion sent while TX wait was high");
            failures++;
        end
        tl_tx_wait_i = 1'b0;
        foreach (bp_ops[i]) begin
            wait_cpl(b, ok, 40);
            if (!ok) begin
                $display("Completion %0d lost after back-pressure", i);
                failures++;
            end else begin
                verify_cpl(b, bp_ops[i]);
            end
        end

        // PERST pulse holds the TLP logic until the start delay passes again
        pcie_rstn_i = 1'b0;
        repeat (3) @(negedge cfg_clk);
        check_led("led_o[2]", led_o & 4'b0100, 4'b0100);
        repeat (37) @(negedge cfg_clk);
        pcie_rstn_i = 1'b1;
        repeat (30) @(negedge cfg_clk);
        check_led("led_o[2]", led_o & 4'b0100, 4'b0100);
        repeat (50) @(negedge cfg_clk);
        check_led("led_o[2]", led_o & 4'b0100, 4'b0000);
        read_back(`FMT_MRD32, 32'h10);
        read_back(`FMT_MRD64, 32'h24);
        read_back(`FMT_MRD32, 32'h40);
        read_back(`FMT_MRD64, 32'hFC);

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== pcie_mmio.f ====
+incdir+include
src/pcie_mmio_pkg.sv
src/pcie_rst_seq.sv
src/status_led.sv
src/tlp_mem_dec.sv
src/mmio_target.sv
src/cpl_tx_queue.sv
src/pcie_mmio_top.sv
test/tb_pcie_mmio.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_pcie_mmio \
    -f pcie_mmio.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
